// File: isa_pkg.sv
package isa_pkg;

    // Major opcodes seen by the checkpoint logic
    typedef enum logic [5:0] {
        op_other = 6'h00,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05
    } opcode_t;

    // Conditional branch format, offset counts words
    typedef struct packed {
        opcode_t            opcode;
        logic [4:0]         rs;
        logic [4:0]         rt;
        logic signed [15:0] offset;
    } branch_fmt_t;

    // Jump format, target counts words within the current 256 MB region
    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target;
    } jump_fmt_t;

    // Same 32-bit word seen through either format
    typedef union packed {
        branch_fmt_t branch;
        jump_fmt_t   jump;
    } instr_word_t;

endpackage

// File: core_pkg.sv
package core_pkg;

    // Byte address
    typedef logic [31:0] addr_t;

    // Slot in the 16-entry reorder buffer
    typedef logic [3:0] rob_idx_t;

    // Physical register number
    typedef logic [3:0] phys_idx_t;

    // One bit per physical register, set when free
    typedef logic [15:0] free_list_t;

endpackage

// File: branch_decode.sv
`timescale 1ns/1ns

module branch_decode #(
    parameter int NUM_CHECKPOINTS = 4
) (
    input  isa_pkg::instr_word_t       instr,
    input  core_pkg::addr_t            pc,
    input  logic                       dispatch_valid,
    input  logic                       complete_valid,
    input  logic [NUM_CHECKPOINTS-1:0] b_mask,
    output logic                       dispatch_ready,
    output logic                       alloc_valid,
    output logic [NUM_CHECKPOINTS-1:0] alloc_tag,
    output logic                       alloc_is_jump,
    output logic                       alloc_pred_taken,
    output core_pkg::addr_t            alloc_pred_target,
    output core_pkg::addr_t            alloc_recovery_pc
);
    import isa_pkg::*;
    import core_pkg::*;

    addr_t pc_plus4;
    addr_t branch_target;
    addr_t jump_target;
    logic  is_branch;
    logic  is_jump;

    // Both formats place the opcode in the same upper bits
    assign is_branch = (instr.branch.opcode == op_beq) || (instr.branch.opcode == op_bne);
    assign is_jump   = (instr.jump.opcode == op_jal);

    assign pc_plus4 = pc + 32'd4;

    // Sign-extended word offset, relative to the next instruction
    assign branch_target = pc_plus4 + {{14{instr.branch.offset[15]}}, instr.branch.offset, 2'b00};

    // Region bits come from pc + 4, the rest from the jump field
    assign jump_target = {pc_plus4[31:28], instr.jump.target, 2'b00};

    // Backward branches are guessed taken, jumps always are
    assign alloc_is_jump     = is_jump;
    assign alloc_pred_taken  = is_jump || instr.branch.offset[15];
    assign alloc_pred_target = is_jump ? jump_target : branch_target;

    // The path not followed is where fetch resumes on a wrong guess
    assign alloc_recovery_pc = alloc_pred_taken ? pc_plus4 : alloc_pred_target;

    // No new branch while every tag is busy or a branch is completing
    assign dispatch_ready = !(&b_mask) && !complete_valid;

    // Lowest clear bit of the live mask
    assign alloc_tag = ~b_mask & (b_mask + {{(NUM_CHECKPOINTS-1){1'b0}}, 1'b1});

    assign alloc_valid = dispatch_valid && dispatch_ready && (is_branch || is_jump);

endmodule

// File: branch_stack.sv
`timescale 1ns/1ns

module branch_stack #(
    parameter int NUM_CHECKPOINTS = 4,
    parameter int NUM_ARCH_REGS   = 8
) (
    input  logic                                              clock,
    input  logic                                              reset,
    input  logic                                              alloc_valid,
    input  logic [NUM_CHECKPOINTS-1:0]                        alloc_tag,
    input  logic                                              alloc_is_jump,
    input  logic                                              alloc_pred_taken,
    input  core_pkg::addr_t                                   alloc_pred_target,
    input  core_pkg::addr_t                                   alloc_recovery_pc,
    input  logic [NUM_ARCH_REGS*$bits(core_pkg::phys_idx_t)-1:0] map_table_in,
    input  core_pkg::free_list_t                              free_list_in,
    input  core_pkg::rob_idx_t                                rob_tail_in,
    input  logic                                              complete_valid,
    input  logic [NUM_CHECKPOINTS-1:0]                        complete_tag,
    input  logic                                              freed_valid,
    input  core_pkg::free_list_t                              freed_regs,
    input  logic [NUM_CHECKPOINTS-1:0]                        squash_tags,
    output logic [NUM_CHECKPOINTS-1:0]                        b_mask,
    output logic                                              sel_live,
    output logic                                              sel_is_jump,
    output logic                                              sel_pred_taken,
    output core_pkg::addr_t                                   sel_pred_target,
    output core_pkg::addr_t                                   sel_recovery_pc,
    output core_pkg::rob_idx_t                                sel_rob_tail,
    output core_pkg::free_list_t                              sel_free_list,
    output logic [NUM_ARCH_REGS*$bits(core_pkg::phys_idx_t)-1:0] sel_map_table,
    output logic [NUM_CHECKPOINTS*NUM_CHECKPOINTS-1:0]        dep_masks
);
    import core_pkg::*;

    // Checkpoint contents, one slot per tag
    logic                               is_jump_q     [NUM_CHECKPOINTS];
    logic                               pred_taken_q  [NUM_CHECKPOINTS];
    addr_t                              pred_target_q [NUM_CHECKPOINTS];
    addr_t                              recovery_pc_q [NUM_CHECKPOINTS];
    rob_idx_t                           rob_tail_q    [NUM_CHECKPOINTS];
    free_list_t                         free_list_q   [NUM_CHECKPOINTS];
    logic [NUM_ARCH_REGS*4-1:0]         map_table_q   [NUM_CHECKPOINTS];
    logic [NUM_CHECKPOINTS-1:0]         dep_mask_q    [NUM_CHECKPOINTS];

    logic [NUM_CHECKPOINTS-1:0] resolve_clear;

    assign resolve_clear = complete_valid ? complete_tag : '0;
    assign sel_live      = |(complete_tag & b_mask);

    // Read port addressed by the one-hot completing tag
    always_comb begin
        sel_is_jump     = 1'b0;
        sel_pred_taken  = 1'b0;
        sel_pred_target = '0;
        sel_recovery_pc = '0;
        sel_rob_tail    = '0;
        sel_free_list   = '0;
        sel_map_table   = '0;
        for (int i = 0; i < NUM_CHECKPOINTS; i++) begin
            if (complete_tag[i]) begin
                sel_is_jump     = is_jump_q[i];
                sel_pred_taken  = pred_taken_q[i];
                sel_pred_target = pred_target_q[i];
                sel_recovery_pc = recovery_pc_q[i];
                sel_rob_tail    = rob_tail_q[i];
                sel_free_list   = free_list_q[i];
                sel_map_table   = map_table_q[i];
            end
        end
    end

    // Dead slots report an empty mask so they never join a squash
    always_comb begin
        for (int i = 0; i < NUM_CHECKPOINTS; i++) begin
            dep_masks[i*NUM_CHECKPOINTS +: NUM_CHECKPOINTS] = b_mask[i] ? dep_mask_q[i] : '0;
        end
    end

    // Completing tag and its squashed dependents leave together
    always_ff @(posedge clock) begin
        if (reset) begin
            b_mask <= '0;
        end else begin
            b_mask <= (b_mask & ~(resolve_clear | squash_tags)) | (alloc_valid ? alloc_tag : '0);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_CHECKPOINTS; i++) begin
            if (alloc_valid && alloc_tag[i]) begin
                is_jump_q[i]     <= alloc_is_jump;
                pred_taken_q[i]  <= alloc_pred_taken;
                pred_target_q[i] <= alloc_pred_target;
                recovery_pc_q[i] <= alloc_recovery_pc;
                rob_tail_q[i]    <= rob_tail_in;
                free_list_q[i]   <= free_list_in;
                map_table_q[i]   <= map_table_in;
                // New branch depends on every branch still in flight
                dep_mask_q[i]    <= b_mask;
            end else begin
                dep_mask_q[i] <= dep_mask_q[i] & ~resolve_clear;
                if (freed_valid && b_mask[i]) begin
                    free_list_q[i] <= free_list_q[i] | freed_regs;
                end
            end
        end
    end

endmodule

// File: branch_resolve.sv
`timescale 1ns/1ns

module branch_resolve (
    input  logic            complete_valid,
    input  logic            complete_taken,
    input  core_pkg::addr_t complete_target,
    input  logic            sel_live,
    input  logic            sel_is_jump,
    input  logic            sel_pred_taken,
    input  core_pkg::addr_t sel_pred_target,
    input  core_pkg::addr_t sel_recovery_pc,
    output logic            resolve_fire,
    output logic            mispredict,
    output core_pkg::addr_t correct_pc
);

    logic taken_wrong;
    logic target_wrong;
    logic went_taken;

    // Completions for tags that are not live are dropped here
    assign resolve_fire = complete_valid && sel_live;

    assign taken_wrong  = complete_taken != sel_pred_taken;
    assign target_wrong = complete_target != sel_pred_target;

    // A jump always transfers control
    assign went_taken = complete_taken || sel_is_jump;

    // Jumps only miss on target; branches miss on direction,
    // or on target when the branch was taken
    always_comb begin
        if (!resolve_fire) begin
            mispredict = 1'b0;
        end else if (sel_is_jump) begin
            mispredict = target_wrong;
        end else begin
            mispredict = taken_wrong || (complete_taken && target_wrong);
        end
    end

    assign correct_pc = went_taken ? complete_target : sel_recovery_pc;

endmodule

// File: recovery_select.sv
`timescale 1ns/1ns

module recovery_select #(
    parameter int NUM_CHECKPOINTS = 4,
    parameter int NUM_ARCH_REGS   = 8
) (
    input  logic                                              clock,
    input  logic                                              reset,
    input  logic                                              resolve_fire,
    input  logic                                              mispredict,
    input  core_pkg::addr_t                                   correct_pc,
    input  logic [NUM_CHECKPOINTS-1:0]                        complete_tag,
    input  logic [NUM_CHECKPOINTS*NUM_CHECKPOINTS-1:0]        dep_masks,
    input  core_pkg::rob_idx_t                                sel_rob_tail,
    input  core_pkg::free_list_t                              sel_free_list,
    input  logic [NUM_ARCH_REGS*$bits(core_pkg::phys_idx_t)-1:0] sel_map_table,
    output logic [NUM_CHECKPOINTS-1:0]                        squash_tags,
    output logic                                              resolve_valid,
    output logic                                              restore_valid,
    output core_pkg::addr_t                                   pc_restore,
    output core_pkg::rob_idx_t                                rob_tail_restore,
    output core_pkg::free_list_t                              free_list_restore,
    output logic [NUM_ARCH_REGS*$bits(core_pkg::phys_idx_t)-1:0] map_table_restore,
    output logic [NUM_CHECKPOINTS-1:0]                        squash_mask
);

    logic restore_fire;

    assign restore_fire = resolve_fire && mispredict;

    // The missed branch plus every live entry that depends on it
    always_comb begin
        squash_tags = '0;
        if (restore_fire) begin
            squash_tags = complete_tag;
            for (int i = 0; i < NUM_CHECKPOINTS; i++) begin
                if (|(dep_masks[i*NUM_CHECKPOINTS +: NUM_CHECKPOINTS] & complete_tag)) begin
                    squash_tags[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            resolve_valid <= 1'b0;
            restore_valid <= 1'b0;
            squash_mask   <= '0;
        end else begin
            resolve_valid <= resolve_fire;
            restore_valid <= restore_fire;
            squash_mask   <= squash_tags;
        end
    end

    // Restore data reads as zero outside a recovery cycle
    always_ff @(posedge clock) begin
        pc_restore        <= restore_fire ? correct_pc : '0;
        rob_tail_restore  <= restore_fire ? sel_rob_tail : '0;
        free_list_restore <= restore_fire ? sel_free_list : '0;
        map_table_restore <= restore_fire ? sel_map_table : '0;
    end

endmodule

// File: speculation_unit.sv
`timescale 1ns/1ns

module speculation_unit #(
    parameter int NUM_CHECKPOINTS = 4,
    parameter int NUM_ARCH_REGS   = 8
) (
    input  logic                                              clock,
    input  logic                                              reset,
    input  logic                                              dispatch_valid,
    input  isa_pkg::instr_word_t                              dispatch_instr,
    input  core_pkg::addr_t                                   dispatch_pc,
    input  logic [NUM_ARCH_REGS*$bits(core_pkg::phys_idx_t)-1:0] map_table_in,
    input  core_pkg::free_list_t                              free_list_in,
    input  core_pkg::rob_idx_t                                rob_tail_in,
    input  logic                                              complete_valid,
    input  logic [NUM_CHECKPOINTS-1:0]                        complete_tag,
    input  logic                                              complete_taken,
    input  core_pkg::addr_t                                   complete_target,
    input  logic                                              freed_valid,
    input  core_pkg::free_list_t                              freed_regs,
    output logic                                              dispatch_ready,
    output logic [NUM_CHECKPOINTS-1:0]                        dispatch_tag,
    output logic [NUM_CHECKPOINTS-1:0]                        b_mask,
    output logic                                              restore_valid,
    output core_pkg::addr_t                                   pc_restore,
    output core_pkg::rob_idx_t                                rob_tail_restore,
    output core_pkg::free_list_t                              free_list_restore,
    output logic [NUM_ARCH_REGS*$bits(core_pkg::phys_idx_t)-1:0] map_table_restore,
    output logic [NUM_CHECKPOINTS-1:0]                        squash_mask,
    output logic                                              resolve_valid
);
    import core_pkg::*;

    // Decode to stack
    logic  alloc_valid;
    logic  alloc_is_jump;
    logic  alloc_pred_taken;
    addr_t alloc_pred_target;
    addr_t alloc_recovery_pc;

    // Stack read port for the completing tag
    logic                                      sel_live;
    logic                                      sel_is_jump;
    logic                                      sel_pred_taken;
    addr_t                                     sel_pred_target;
    addr_t                                     sel_recovery_pc;
    rob_idx_t                                  sel_rob_tail;
    free_list_t                                sel_free_list;
    logic [NUM_ARCH_REGS*$bits(phys_idx_t)-1:0] sel_map_table;
    logic [NUM_CHECKPOINTS*NUM_CHECKPOINTS-1:0] dep_masks;

    // Resolve to recovery, and squash back to the stack
    logic                       resolve_fire;
    logic                       mispredict;
    addr_t                      correct_pc;
    logic [NUM_CHECKPOINTS-1:0] squash_tags;

    branch_decode #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS)) u_decode (
        .instr(dispatch_instr), .pc(dispatch_pc), .dispatch_valid(dispatch_valid),
        .complete_valid(complete_valid), .b_mask(b_mask), .dispatch_ready(dispatch_ready),
        .alloc_valid(alloc_valid), .alloc_tag(dispatch_tag), .alloc_is_jump(alloc_is_jump),
        .alloc_pred_taken(alloc_pred_taken), .alloc_pred_target(alloc_pred_target),
        .alloc_recovery_pc(alloc_recovery_pc)
    );

    branch_stack #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS), .NUM_ARCH_REGS(NUM_ARCH_REGS)) u_stack (
        .clock(clock), .reset(reset), .alloc_valid(alloc_valid), .alloc_tag(dispatch_tag),
        .alloc_is_jump(alloc_is_jump), .alloc_pred_taken(alloc_pred_taken),
        .alloc_pred_target(alloc_pred_target), .alloc_recovery_pc(alloc_recovery_pc),
        .map_table_in(map_table_in), .free_list_in(free_list_in), .rob_tail_in(rob_tail_in),
        .complete_valid(complete_valid), .complete_tag(complete_tag),
        .freed_valid(freed_valid), .freed_regs(freed_regs), .squash_tags(squash_tags),
        .b_mask(b_mask), .sel_live(sel_live), .sel_is_jump(sel_is_jump),
        .sel_pred_taken(sel_pred_taken), .sel_pred_target(sel_pred_target),
        .sel_recovery_pc(sel_recovery_pc), .sel_rob_tail(sel_rob_tail),
        .sel_free_list(sel_free_list), .sel_map_table(sel_map_table), .dep_masks(dep_masks)
    );

    branch_resolve u_resolve (
        .complete_valid(complete_valid), .complete_taken(complete_taken),
        .complete_target(complete_target), .sel_live(sel_live), .sel_is_jump(sel_is_jump),
        .sel_pred_taken(sel_pred_taken), .sel_pred_target(sel_pred_target),
        .sel_recovery_pc(sel_recovery_pc), .resolve_fire(resolve_fire),
        .mispredict(mispredict), .correct_pc(correct_pc)
    );

    recovery_select #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS), .NUM_ARCH_REGS(NUM_ARCH_REGS)) u_recovery (
        .clock(clock), .reset(reset), .resolve_fire(resolve_fire), .mispredict(mispredict),
        .correct_pc(correct_pc), .complete_tag(complete_tag), .dep_masks(dep_masks),
        .sel_rob_tail(sel_rob_tail), .sel_free_list(sel_free_list),
        .sel_map_table(sel_map_table), .squash_tags(squash_tags),
        .resolve_valid(resolve_valid), .restore_valid(restore_valid),
        .pc_restore(pc_restore), .rob_tail_restore(rob_tail_restore),
        .free_list_restore(free_list_restore), .map_table_restore(map_table_restore),
        .squash_mask(squash_mask)
    );

endmodule

// File: speculation_unit_assert.sv
`timescale 1ns/1ns

module speculation_unit_assert #(
    parameter int NUM_CHECKPOINTS = 4
) (
    input logic                       clock,
    input logic                       reset,
    input logic [NUM_CHECKPOINTS-1:0] b_mask,
    input logic                       dispatch_ready,
    input logic                       resolve_valid,
    input logic                       restore_valid,
    input logic [NUM_CHECKPOINTS-1:0] squash_mask
);

    // A restore only follows a branch that resolved
    restore_implies_resolve: assert property (
        @(posedge clock) disable iff (reset) restore_valid |-> resolve_valid
    ) else $error("restore_valid is high without resolve_valid");

    squash_only_on_restore: assert property (
        @(posedge clock) disable iff (reset) !restore_valid |-> (squash_mask == '0)
    ) else $error("squash_mask is nonzero outside a restore");

    // All tags busy
    no_ready_when_full: assert property (
        @(posedge clock) disable iff (reset) (&b_mask) |-> !dispatch_ready
    ) else $error("dispatch_ready is high while every tag is in use");

endmodule

// File: speculation_unit_tb.sv
`timescale 1ns/1ns

module speculation_unit_tb;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int NUM_CHECKPOINTS = 4;
    localparam int NUM_ARCH_REGS   = 8;
    // Nine input columns and eight expected columns per vector
    localparam int FIELDS          = 17;
    localparam int MAX_VECTORS     = 64;

    logic                       clock;
    logic                       reset;
    logic                       dispatch_valid;
    instr_word_t                dispatch_instr;
    addr_t                      dispatch_pc;
    logic [NUM_ARCH_REGS*4-1:0] map_table_in;
    free_list_t                 free_list_in;
    rob_idx_t                   rob_tail_in;
    logic                       complete_valid;
    logic [NUM_CHECKPOINTS-1:0] complete_tag;
    logic                       complete_taken;
    addr_t                      complete_target;
    logic                       freed_valid;
    free_list_t                 freed_regs;
    logic                       dispatch_ready;
    logic [NUM_CHECKPOINTS-1:0] dispatch_tag;
    logic [NUM_CHECKPOINTS-1:0] b_mask;
    logic                       restore_valid;
    addr_t                      pc_restore;
    rob_idx_t                   rob_tail_restore;
    free_list_t                 free_list_restore;
    logic [NUM_ARCH_REGS*4-1:0] map_table_restore;
    logic [NUM_CHECKPOINTS-1:0] squash_mask;
    logic                       resolve_valid;

    logic [31:0] golden [FIELDS*MAX_VECTORS];
    int          num_vectors;
    int          cycle_count;
    int          cycle_limit;

    speculation_unit #(
        .NUM_CHECKPOINTS(NUM_CHECKPOINTS),
        .NUM_ARCH_REGS(NUM_ARCH_REGS)
    ) uut (
        .clock(clock), .reset(reset), .dispatch_valid(dispatch_valid),
        .dispatch_instr(dispatch_instr), .dispatch_pc(dispatch_pc),
        .map_table_in(map_table_in), .free_list_in(free_list_in), .rob_tail_in(rob_tail_in),
        .complete_valid(complete_valid), .complete_tag(complete_tag),
        .complete_taken(complete_taken), .complete_target(complete_target),
        .freed_valid(freed_valid), .freed_regs(freed_regs), .dispatch_ready(dispatch_ready),
        .dispatch_tag(dispatch_tag), .b_mask(b_mask), .restore_valid(restore_valid),
        .pc_restore(pc_restore), .rob_tail_restore(rob_tail_restore),
        .free_list_restore(free_list_restore), .map_table_restore(map_table_restore),
        .squash_mask(squash_mask), .resolve_valid(resolve_valid)
    );

    bind speculation_unit speculation_unit_assert #(.NUM_CHECKPOINTS(NUM_CHECKPOINTS)) u_assert (
        .clock(clock), .reset(reset), .b_mask(b_mask), .dispatch_ready(dispatch_ready),
        .resolve_valid(resolve_valid), .restore_valid(restore_valid),
        .squash_mask(squash_mask)
    );

    always #2 clock = ~clock;

    // Guard against a stuck run
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Control column holds dispatch, complete, taken and freed strobes
    task automatic drive_vector(input int base);
        dispatch_valid  = golden[base][3];
        complete_valid  = golden[base][2];
        complete_taken  = golden[base][1];
        freed_valid     = golden[base][0];
        dispatch_instr  = golden[base+1];
        dispatch_pc     = golden[base+2];
        map_table_in    = golden[base+3];
        free_list_in    = golden[base+4][15:0];
        rob_tail_in     = golden[base+5][3:0];
        complete_tag    = golden[base+6][NUM_CHECKPOINTS-1:0];
        complete_target = golden[base+7];
        freed_regs      = golden[base+8][15:0];
    endtask

    // Ready and tag are combinational, so they are seen before the edge
    task automatic check_dispatch_outputs(input int v, input int base);
        check_value(32'(dispatch_ready), 32'(golden[base+9][2]),
                    $sformatf("vector %0d dispatch_ready", v));
        check_value(32'(dispatch_tag), golden[base+10], $sformatf("vector %0d dispatch_tag", v));
    endtask

    task automatic check_registered_outputs(input int v, input int base);
        check_value(32'(b_mask), golden[base+11], $sformatf("vector %0d b_mask", v));
        check_value(32'(resolve_valid), 32'(golden[base+9][1]),
                    $sformatf("vector %0d resolve_valid", v));
        check_value(32'(restore_valid), 32'(golden[base+9][0]),
                    $sformatf("vector %0d restore_valid", v));
        check_value(pc_restore, golden[base+12], $sformatf("vector %0d pc_restore", v));
        check_value(32'(rob_tail_restore), golden[base+13],
                    $sformatf("vector %0d rob_tail_restore", v));
        check_value(32'(free_list_restore), golden[base+14],
                    $sformatf("vector %0d free_list_restore", v));
        check_value(map_table_restore, golden[base+15],
                    $sformatf("vector %0d map_table_restore", v));
        check_value(32'(squash_mask), golden[base+16], $sformatf("vector %0d squash_mask", v));
    endtask

    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        dispatch_valid  = 1'b0;
        dispatch_instr  = '0;
        dispatch_pc     = '0;
        map_table_in    = '0;
        free_list_in    = '0;
        rob_tail_in     = '0;
        complete_valid  = 1'b0;
        complete_tag    = '0;
        complete_taken  = 1'b0;
        complete_target = '0;
        freed_valid     = 1'b0;
        freed_regs      = '0;
        cycle_count     = 0;
        num_vectors     = 0;

        // Unloaded slots get a value no control column can hold
        for (int i = 0; i < FIELDS*MAX_VECTORS; i++) begin
            golden[i] = {16'hdead, 16'(i)};
        end
        $readmemh("speculation_golden.txt", golden);
        while (num_vectors < MAX_VECTORS && golden[num_vectors*FIELDS] <= 32'hf) begin
            num_vectors = num_vectors + 1;
        end
        cycle_limit = num_vectors + 20;
        if (num_vectors == 0) begin
            $display("No stimulus vectors could be read from speculation_golden.txt");
            $display("Errors found");
            $fatal(1, "no stimulus vectors were run");
        end

        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int v = 0; v < num_vectors; v++) begin
            @(negedge clock);
            drive_vector(v * FIELDS);
            #1;
            check_dispatch_outputs(v, v * FIELDS);
            @(posedge clock);
            #1;
            check_registered_outputs(v, v * FIELDS);
        end

        $display("No errors");
        $finish;
    end

endmodule

// File: speculation_golden.txt
// ctl bits 3..0: dispatch_valid complete_valid complete_taken freed_valid
// in:  ctl instr pc map_table free_list rob_tail complete_tag complete_target freed_regs
// out: flg(ready resolve restore) dispatch_tag b_mask pc rob_tail free_list map_table squash
0 00000000 00000000 00000000 0000 0 0 00000000 0000  4 1 0 00000000 0 0000 00000000 0
8 1000fffc 00001000 76543210 ff00 3 0 00000000 0000  4 1 1 00000000 0 0000 00000000 0
8 14000008 00002000 11111111 f0f0 5 0 00000000 0000  4 2 3 00000000 0 0000 00000000 0
8 0c123456 30000100 22222222 0f00 7 0 00000000 0000  4 4 7 00000000 0 0000 00000000 0
8 10000002 00004000 33333333 00f0 9 0 00000000 0000  4 8 f 00000000 0 0000 00000000 0
8 10000002 00005000 44444444 0000 a 0 00000000 0000  0 0 f 00000000 0 0000 00000000 0
4 00000000 00000000 00000000 0000 0 8 0000400c 0000  2 0 7 00000000 0 0000 00000000 0
0 00000000 00000000 00000000 0000 0 0 00000000 0000  4 8 7 00000000 0 0000 00000000 0
1 00000000 00000000 00000000 0000 0 0 00000000 000a  4 8 7 00000000 0 0000 00000000 0
6 00000000 00000000 00000000 0000 0 2 00002024 0000  3 8 1 00002024 5 f0fa 11111111 6
0 00000000 00000000 00000000 0000 0 0 00000000 0000  4 2 1 00000000 0 0000 00000000 0
8 0c000100 50000200 44444444 1234 b 0 00000000 0000  4 2 3 00000000 0 0000 00000000 0
6 00000000 00000000 00000000 0000 0 2 50000800 0000  3 4 1 50000800 b 1234 44444444 2
4 00000000 00000000 00000000 0000 0 4 00000000 0000  0 2 1 00000000 0 0000 00000000 0
6 00000000 00000000 00000000 0000 0 1 00000ff4 0000  2 2 0 00000000 0 0000 00000000 0
8 20001234 00006000 00000000 0000 0 0 00000000 0000  4 1 0 00000000 0 0000 00000000 0
8 1000fff0 00007000 55555555 8001 2 0 00000000 0000  4 1 1 00000000 0 0000 00000000 0
4 00000000 00000000 00000000 0000 0 1 00007004 0000  3 2 0 00007004 2 8001 55555555 1
0 00000000 00000000 00000000 0000 0 0 00000000 0000  4 1 0 00000000 0 0000 00000000 0
8 0c000010 6ffffffc 66666666 0001 4 0 00000000 0000  4 1 1 00000000 0 0000 00000000 0
6 00000000 00000000 00000000 0000 0 1 70000040 0000  2 2 0 00000000 0 0000 00000000 0
0 00000000 00000000 00000000 0000 0 0 00000000 0000  4 1 0 00000000 0 0000 00000000 0

// File: all.f
isa_pkg.sv
core_pkg.sv
branch_decode.sv
branch_stack.sv
branch_resolve.sv
recovery_select.sv
speculation_unit.sv
speculation_unit_assert.sv
speculation_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the speculation unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f all.f --top-module speculation_unit_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vspeculation_unit_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -qx "No errors" "$log"; then
    exit 0
fi
echo "Simulation failed, see $log"
exit 1
